//--- rtl/uart_pkg.sv
package uart_pkg;

	// clk cycles per bit, kept small for short simulations
	localparam int BAUD_DIV   = 16;
	localparam int BAUD_CNT_W = $clog2(BAUD_DIV);

	// character width, one start and one stop bit around it
	localparam int DATA_BITS = 8;

	// status vector layout
	localparam int STATUS_BITS   = 5;
	localparam int ST_TX_BUSY    = 0;  // live copy of the transmitter
	localparam int ST_RX_READY   = 1;  // sticky, new character in rx_data
	localparam int ST_PARITY_ERR = 2;  // sticky
	localparam int ST_FRAME_ERR  = 3;  // sticky, stop bit seen low
	localparam int ST_OVERRUN    = 4;  // sticky, character lost

endpackage

//--- rtl/baud_gen.sv
`timescale 1ns/1ps

module baud_gen import uart_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	output logic baud_tick
);

	logic [BAUD_CNT_W-1:0] cnt;

	// free running from reset release
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (cnt == BAUD_CNT_W'(BAUD_DIV - 1)) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	assign baud_tick = (cnt == BAUD_CNT_W'(BAUD_DIV - 1));  // one clk per bit period

	// consumers count ticks, so a stretched pulse would double count a bit
	a_tick_single: assert property (
		@(posedge clk) disable iff (!rst_n)
		baud_tick |=> !baud_tick
	) else $error("baud_tick high on two consecutive cycles");

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 baud_tick,
	input  logic                 tx_en,
	input  logic                 n_parity,   // high means no parity bit
	input  logic                 ev_parity,  // even when high, odd otherwise
	input  logic                 tx_start,
	input  logic [DATA_BITS-1:0] txd_in,
	output logic                 tx_ok,
	output logic                 tx_busy,
	output logic                 txd
);

	typedef enum logic {
		TX_IDLE,
		TX_DATA
	} tx_state_t;

	tx_state_t              state;
	logic [3:0]             tx_cnt;     // ticks spent in the frame
	logic [3:0]             last_cnt;   // end count, latched at load
	logic [DATA_BITS+2:0]   txd_out_r;  // stop, parity, data, start
	logic                   par_bit;
	logic [DATA_BITS+2:0]   frame;

	// parity over the raw character, same rule the receiver checks
	assign par_bit = ev_parity ? ^txd_in : ~^txd_in;

	// without parity the spare slot is just a second high bit, never sent
	always_comb begin
		if (n_parity) begin
			frame = {2'b11, txd_in, 1'b0};
		end else begin
			frame = {1'b1, par_bit, txd_in, 1'b0};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= TX_IDLE;
			tx_cnt    <= '0;
			last_cnt  <= '0;
			txd_out_r <= '1;
		end else if (!tx_en) begin
			// disable aborts any frame in flight
			state     <= TX_IDLE;
			tx_cnt    <= '0;
			txd_out_r <= '1;
		end else if (baud_tick) begin
			case (state)
				TX_IDLE: begin
					if (tx_start) begin
						txd_out_r <= frame;
						tx_cnt    <= '0;
						// 10 ticks plain, 11 with parity
						last_cnt  <= n_parity ? 4'(DATA_BITS + 1) : 4'(DATA_BITS + 2);
						state     <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (tx_cnt == last_cnt) begin
						state  <= TX_IDLE;  // stop bit already on the line
						tx_cnt <= '0;
					end else begin
						tx_cnt    <= tx_cnt + 1'b1;
						txd_out_r <= {1'b1, txd_out_r[DATA_BITS+2:1]};  // lsb first
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	assign txd     = txd_out_r[0];
	assign tx_busy = (state == TX_DATA);
	assign tx_ok   = tx_en && (state == TX_IDLE);  // software polls this before writing

	// the line must rest at mark level between frames
	a_idle_mark: assert property (
		@(posedge clk) disable iff (!rst_n)
		(state == TX_IDLE) |-> txd
	) else $error("txd low while transmitter idle");

endmodule

//--- rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 n_parity,
	input  logic                 ev_parity,
	input  logic                 rxd,
	output logic [DATA_BITS-1:0] rx_data,
	output logic                 rx_done,
	output logic                 rx_parity_bad,
	output logic                 rx_stop_bad
);

	typedef enum logic {
		RX_IDLE,
		RX_RECV
	} rx_state_t;

	rx_state_t             state;
	logic                  rxd_s1;
	logic                  rxd_s2;
	logic                  rxd_d;
	logic                  fall;
	logic                  sample;
	logic                  in_data;
	logic [BAUD_CNT_W-1:0] cnt;      // cycles to next sample point
	logic [3:0]            idx;      // 0 start, then data, parity, stop
	logic [3:0]            last_idx;
	logic                  par_en;
	logic                  ev_r;
	logic                  par_bit;
	logic                  par_exp;
	logic [DATA_BITS-1:0]  shift_r;

	// two flop synchronizer plus one more for edge detect
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rxd_s1 <= 1'b1;
			rxd_s2 <= 1'b1;
			rxd_d  <= 1'b1;
		end else begin
			rxd_s1 <= rxd;
			rxd_s2 <= rxd_s1;
			rxd_d  <= rxd_s2;
		end
	end

	assign fall     = rxd_d & ~rxd_s2;
	assign sample   = (state == RX_RECV) && (cnt == '0);
	assign in_data  = (idx != 4'd0) && (idx <= 4'(DATA_BITS));
	assign last_idx = par_en ? 4'(DATA_BITS + 2) : 4'(DATA_BITS + 1);
	assign par_exp  = ev_r ? ^shift_r : ~^shift_r;  // same rule as uart_tx

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state         <= RX_IDLE;
			cnt           <= '0;
			idx           <= '0;
			par_en        <= 1'b0;
			ev_r          <= 1'b0;
			rx_done       <= 1'b0;
			rx_parity_bad <= 1'b0;
			rx_stop_bad   <= 1'b0;
		end else begin
			rx_done       <= 1'b0;
			rx_parity_bad <= 1'b0;
			rx_stop_bad   <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (fall) begin
						state  <= RX_RECV;
						cnt    <= BAUD_CNT_W'(BAUD_DIV / 2 - 1);  // aim at mid start bit
						idx    <= '0;
						par_en <= ~n_parity;
						ev_r   <= ev_parity;
					end
				end
				RX_RECV: begin
					if (cnt != '0) begin
						cnt <= cnt - 1'b1;
					end else begin
						cnt <= BAUD_CNT_W'(BAUD_DIV - 1);
						if (idx == 4'd0 && rxd_s2) begin
							state <= RX_IDLE;  // start bit gone high again
						end else if (idx == last_idx) begin
							state         <= RX_IDLE;
							rx_done       <= 1'b1;
							rx_stop_bad   <= ~rxd_s2;
							rx_parity_bad <= par_en && (par_bit != par_exp);
						end else begin
							idx <= idx + 1'b1;
						end
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// character assembly and parity capture
	always_ff @(posedge clk) begin
		if (sample && in_data) begin
			shift_r <= {rxd_s2, shift_r[DATA_BITS-1:1]};  // lsb arrives first
		end
		if (sample && par_en && idx == 4'(DATA_BITS + 1)) begin
			par_bit <= rxd_s2;
		end
		if (sample && idx == last_idx) begin
			rx_data <= shift_r;
		end
	end

	// error flags mean nothing outside the done pulse
	a_flags_with_done: assert property (
		@(posedge clk) disable iff (!rst_n)
		(rx_parity_bad || rx_stop_bad) |-> rx_done
	) else $error("rx error flag without rx_done");

endmodule

//--- rtl/line_status.sv
`timescale 1ns/1ps

module line_status import uart_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   tx_busy,
	input  logic                   rx_done,
	input  logic                   rx_parity_bad,
	input  logic                   rx_stop_bad,
	input  logic                   status_rd,
	output logic [STATUS_BITS-1:0] status
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			status <= '0;
		end else begin
			status[ST_TX_BUSY] <= tx_busy;  // not sticky

			// set wins over a read in the same cycle
			if (rx_done) begin
				status[ST_RX_READY] <= 1'b1;
			end else if (status_rd) begin
				status[ST_RX_READY] <= 1'b0;
			end

			if (rx_done && rx_parity_bad) begin
				status[ST_PARITY_ERR] <= 1'b1;
			end else if (status_rd) begin
				status[ST_PARITY_ERR] <= 1'b0;
			end

			if (rx_done && rx_stop_bad) begin
				status[ST_FRAME_ERR] <= 1'b1;
			end else if (status_rd) begin
				status[ST_FRAME_ERR] <= 1'b0;
			end

			// previous character never read out
			if (rx_done && status[ST_RX_READY]) begin
				status[ST_OVERRUN] <= 1'b1;
			end else if (status_rd) begin
				status[ST_OVERRUN] <= 1'b0;
			end
		end
	end

	a_overrun_needs_ready: assert property (
		@(posedge clk) disable iff (!rst_n)
		$rose(status[ST_OVERRUN]) |-> $past(status[ST_RX_READY])
	) else $error("overrun flagged with no unread character");

endmodule

//--- rtl/uart_top.sv
`timescale 1ns/1ps

module uart_top import uart_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   tx_en,
	input  logic                   n_parity,
	input  logic                   ev_parity,
	input  logic                   tx_start,
	input  logic [DATA_BITS-1:0]   txd_in,
	input  logic                   status_rd,
	input  logic                   rxd,
	output logic                   txd,
	output logic                   tx_ok,
	output logic [DATA_BITS-1:0]   rx_data,
	output logic                   rx_done,
	output logic [STATUS_BITS-1:0] status
);

	logic baud_tick;
	logic tx_busy;
	logic rx_parity_bad;
	logic rx_stop_bad;

	baud_gen u_baud_gen (
		.clk       (clk),
		.rst_n     (rst_n),
		.baud_tick (baud_tick)
	);

	uart_tx u_uart_tx (
		.clk       (clk),
		.rst_n     (rst_n),
		.baud_tick (baud_tick),
		.tx_en     (tx_en),
		.n_parity  (n_parity),
		.ev_parity (ev_parity),
		.tx_start  (tx_start),
		.txd_in    (txd_in),
		.tx_ok     (tx_ok),
		.tx_busy   (tx_busy),
		.txd       (txd)
	);

	// receiver times itself from the start edge, no baud tick
	uart_rx u_uart_rx (
		.clk           (clk),
		.rst_n         (rst_n),
		.n_parity      (n_parity),
		.ev_parity     (ev_parity),
		.rxd           (rxd),
		.rx_data       (rx_data),
		.rx_done       (rx_done),
		.rx_parity_bad (rx_parity_bad),
		.rx_stop_bad   (rx_stop_bad)
	);

	line_status u_line_status (
		.clk           (clk),
		.rst_n         (rst_n),
		.tx_busy       (tx_busy),
		.rx_done       (rx_done),
		.rx_parity_bad (rx_parity_bad),
		.rx_stop_bad   (rx_stop_bad),
		.status_rd     (status_rd),
		.status        (status)
	);

endmodule

//--- test/uart_tb.sv
`timescale 1ns/1ps

module uart_tb import uart_pkg::*; ();

	localparam logic [STATUS_BITS-1:0] S_RDY = STATUS_BITS'(1 << ST_RX_READY);
	localparam logic [STATUS_BITS-1:0] S_PAR = STATUS_BITS'(1 << ST_PARITY_ERR);
	localparam logic [STATUS_BITS-1:0] S_FRM = STATUS_BITS'(1 << ST_FRAME_ERR);
	localparam logic [STATUS_BITS-1:0] S_OVR = STATUS_BITS'(1 << ST_OVERRUN);
	localparam int NUM_VEC = 9;

	typedef struct packed {
		logic                   direct;    // hand-built frame on rxd, else loopback
		logic                   n_par;
		logic                   ev_par;
		logic [DATA_BITS-1:0]   ch;
		logic                   bad_par;
		logic                   bad_stop;
		logic                   skip_rd;   // no status read before the frame
		logic [STATUS_BITS-1:0] exp;
	} vec_t;

	logic                   clk;
	logic                   rst_n;
	logic                   tx_en;
	logic                   n_parity;
	logic                   ev_parity;
	logic                   tx_start;
	logic [DATA_BITS-1:0]   txd_in;
	logic                   status_rd;
	logic                   rxd;
	logic                   txd;
	logic                   tx_ok;
	logic [DATA_BITS-1:0]   rx_data;
	logic                   rx_done;
	logic [STATUS_BITS-1:0] status;
	logic                   loopback;
	logic                   rxd_drv;
	logic [31:0]            lfsr;
	vec_t                   vecs [NUM_VEC];
	int                     errors = 0;
	int                     timeouts = 0;

	uart_top dut_i (.*);

	assign rxd = loopback ? txd : rxd_drv;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [DATA_BITS-1:0] rand_byte();
		logic [DATA_BITS-1:0] b;
		b = '0;
		repeat (DATA_BITS) begin
			lfsr = lfsr_next(lfsr);  // one step per bit
			b = {lfsr[0], b[DATA_BITS-1:1]};
		end
		return b;
	endfunction

	// bit that makes the count of ones even (ev high) or odd
	function automatic logic parity_for(input logic [DATA_BITS-1:0] ch, input logic ev);
		logic [DATA_BITS-1:0] d;
		int ones;
		d = ch;
		ones = 0;
		repeat (DATA_BITS) begin
			ones += int'(d[0]);
			d = d >> 1;
		end
		return ((ones % 2) == 1) == ev;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			errors++;
			$display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic step_clk();
		@(posedge clk);
		#2;  // drive and sample away from the edge
	endtask

	task automatic read_status();
		status_rd = 1'b1;
		step_clk();
		status_rd = 1'b0;
	endtask

	task automatic load_vectors();
		vecs[0] = '{1'b0, 1'b1, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0, S_RDY};
		vecs[1] = '{1'b0, 1'b1, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0, S_RDY};
		vecs[2] = '{1'b0, 1'b0, 1'b1, 8'h00, 1'b0, 1'b0, 1'b0, S_RDY};  // even
		vecs[3] = '{1'b0, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0, S_RDY};  // odd
		vecs[4] = '{1'b1, 1'b0, 1'b1, 8'h5a, 1'b1, 1'b0, 1'b0, S_RDY | S_PAR};
		vecs[5] = '{1'b1, 1'b1, 1'b0, 8'hc3, 1'b0, 1'b1, 1'b1, S_RDY | S_PAR | S_FRM | S_OVR};
		vecs[6] = '{1'b1, 1'b0, 1'b0, 8'h3c, 1'b0, 1'b0, 1'b0, S_RDY};
		vecs[7] = '{1'b1, 1'b1, 1'b0, 8'h96, 1'b0, 1'b0, 1'b1, S_RDY | S_OVR};
		vecs[8] = '{1'b0, 1'b0, 1'b1, 8'h00, 1'b0, 1'b0, 1'b0, S_RDY};
		// loopback characters come from the lfsr
		for (int i = 0; i < NUM_VEC; i++) begin
			if (!vecs[i].direct) begin
				vecs[i].ch = rand_byte();
			end
		end
	endtask

	task automatic wait_rx_done(output logic seen);
		seen = 1'b0;
		for (int n = 0; n < 16 * BAUD_DIV && !seen; n++) begin
			step_clk();
			seen = rx_done;
		end
		if (!seen) begin
			timeouts++;
			$display("Timeout at %0t: the receiver never pulsed rx_done", $time);
		end
	endtask

	task automatic drive_bit(input logic b);
		rxd_drv = b;
		repeat (BAUD_DIV) step_clk();
	endtask

	task automatic drive_frame(input logic [DATA_BITS-1:0] ch, input logic use_par,
			input logic ev, input logic bad_par, input logic bad_stop);
		logic [DATA_BITS-1:0] d;
		d = ch;
		drive_bit(1'b0);
		repeat (DATA_BITS) begin
			drive_bit(d[0]);  // lsb first
			d = d >> 1;
		end
		if (use_par) drive_bit(parity_for(ch, ev) ^ bad_par);
		drive_bit(!bad_stop);
		rxd_drv = 1'b1;
		repeat (2 * BAUD_DIV) step_clk();  // idle gap before the next start edge
	endtask

	// start a frame and sample txd at each mid-bit
	task automatic send_tx(input logic [DATA_BITS-1:0] ch, input logic use_par, input logic ev);
		logic [DATA_BITS+1:0] bits;
		txd_in = ch;
		tx_start = 1'b1;
		for (int n = 0; n < 2 * BAUD_DIV && txd; n++) step_clk();
		tx_start = 1'b0;
		if (txd) begin
			timeouts++;
			$display("Timeout at %0t: no start bit appeared on txd", $time);
		end else begin
			step_clk();  // status follows tx_busy one clk later
			check_value(32'(tx_ok), 0, "tx_ok during frame");
			check_value(32'(status[ST_TX_BUSY]), 1, "status tx_busy during frame");
			repeat (BAUD_DIV / 2 - 1) step_clk();
			bits = {txd, {(DATA_BITS+1){1'b1}}};
			repeat (DATA_BITS + 1) begin
				repeat (BAUD_DIV) step_clk();
				bits = {txd, bits[DATA_BITS+1:1]};
			end
			check_value(32'(bits[0]), 0, "start bit on txd");
			check_value(32'(bits[DATA_BITS:1]), 32'(ch), "data bits on txd");
			if (use_par) begin
				check_value(32'(bits[DATA_BITS+1]), 32'(parity_for(ch, ev)), "parity bit on txd");
			end else begin
				check_value(32'(bits[DATA_BITS+1]), 1, "stop bit on txd");
			end
			for (int n = 0; n < 4 * BAUD_DIV && !tx_ok; n++) step_clk();
			if (!tx_ok) begin
				timeouts++;
				$display("Timeout at %0t: tx_ok did not come back after the frame", $time);
			end
		end
	endtask

	initial begin
		vec_t                 v;
		logic                 seen;
		logic [DATA_BITS-1:0] rx_cap;
		int                   low_cnt;
		int                   done_cnt;
		rst_n     = 1'b0;
		tx_en     = 1'b1;
		n_parity  = 1'b1;
		ev_parity = 1'b0;
		tx_start  = 1'b0;
		txd_in    = '0;
		status_rd = 1'b0;
		rxd_drv   = 1'b1;
		loopback  = 1'b1;
		lfsr      = 32'h9db6_4571;
		rx_cap    = '0;
		load_vectors();
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;
		check_value(32'(txd), 1, "txd after reset");
		check_value(32'(tx_ok), 1, "tx_ok after reset");
		check_value(32'(status), 0, "status after reset");
		check_value(32'(rx_done), 0, "rx_done after reset");

		for (int r = 0; r < NUM_VEC; r++) begin
			v         = vecs[r];
			n_parity  = v.n_par;
			ev_parity = v.ev_par;
			loopback  = !v.direct;
			if (!v.skip_rd) read_status();
			fork
				begin
					if (v.direct) drive_frame(v.ch, !v.n_par, v.ev_par, v.bad_par, v.bad_stop);
					else send_tx(v.ch, !v.n_par, v.ev_par);
				end
				begin
					wait_rx_done(seen);
					rx_cap = rx_data;  // captured in the rx_done cycle
				end
			join
			step_clk();
			if (seen) check_value(32'(rx_cap), 32'(v.ch), $sformatf("rx_data in row %0d", r));
			check_value(32'(status), 32'(v.exp), $sformatf("status in row %0d", r));
		end

		// disabled transmitter keeps the line at mark
		loopback = 1'b1;
		n_parity = 1'b1;
		tx_en    = 1'b0;
		step_clk();
		check_value(32'(tx_ok), 0, "tx_ok with tx_en low");
		tx_start = 1'b1;
		low_cnt  = 0;
		done_cnt = 0;
		repeat (12 * BAUD_DIV) begin
			step_clk();
			if (!txd) low_cnt++;
			if (rx_done) done_cnt++;
		end
		tx_start = 1'b0;
		check_value(low_cnt, 0, "cycles with txd low while disabled");
		check_value(done_cnt, 0, "rx_done pulses while disabled");
		tx_en = 1'b1;
		read_status();
		check_value(32'(status), 0, "status after final read");

		$display("checks done: %0d wrong values, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- uart.f
rtl/uart_pkg.sv
rtl/baud_gen.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/line_status.sv
rtl/uart_top.sv
test/uart_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the uart testbench with verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module uart_tb \
	-f uart.f -o uart_sim \
	&& ./obj_dir/uart_sim 2>&1 | tee sim.log \
	|| { echo "build or simulation error"; exit 1; }

grep -q "Simulation completed successfully" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }
